// ==== rtl/capture_pkg.sv ====
package capture_pkg;

    // ======================================================================
    // Datapath and FIFO geometry
    // ======================================================================

    // Sample width, also the APB data width
    localparam int data_w = 16;

    // FIFO address width
    // Pointers carry one extra wrap bit on top of this
    localparam int addr_w = 4;

    localparam int depth = 1 << addr_w;     // Words held by the FIFO

    // ======================================================================
    // APB register map
    // ======================================================================

    localparam int paddr_w = 4;             // APB address width

    // Control register
    // Bit 0 enables capture in the write domain
    localparam logic [paddr_w-1:0] reg_ctrl = 4'h0;

    // Status register
    // Bit 0 data available, bit 1 sticky overflow
    localparam logic [paddr_w-1:0] reg_status = 4'h4;

    // Data register
    // A read pops the head word and returns 0 when empty
    localparam logic [paddr_w-1:0] reg_data = 4'h8;

    // Words popped since reset
    localparam logic [paddr_w-1:0] reg_count = 4'hC;

endpackage

// ==== rtl/fifo_ram.sv ====
`timescale 1ns/1ns

// Simple dual-port RAM with independent clocks
// Write port on w_clk, registered read port on r_clk
module fifo_ram import capture_pkg::*; (
    // Write side
    input  logic                  w_clk,
    input  logic                  we,       // Write strobe
    input  logic [addr_w-1:0]     waddr,    // Write address
    input  logic [data_w-1:0]     wdata,    // Write data

    // Read side
    input  logic                  r_clk,
    input  logic [addr_w-1:0]     raddr,    // Read address
    output logic [data_w-1:0]     rdata     // Registered read data
);

    // ======================================================================
    // Storage
    // ======================================================================

    logic [data_w-1:0] mem [depth];         // No reset on the array

    // Write port
    always_ff @(posedge w_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port
    // One cycle of latency, address is sampled at the r_clk edge
    always_ff @(posedge r_clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== rtl/async_fifo.sv ====
`timescale 1ns/1ns

// Dual-clock FIFO with gray-coded pointers
// Each pointer crosses to the other domain through two flops
module async_fifo import capture_pkg::*; (
    input  logic                  rst_,     // Async reset, both domains

    // Write domain
    input  logic                  w_clk,
    input  logic                  w_trigger, // Push, only while w_ready
    input  logic [data_w-1:0]     w_data,    // Push data
    output logic                  w_ready,   // Not full

    // Read domain
    input  logic                  r_clk,
    input  logic                  r_trigger, // Pop, only while r_ready
    output logic [data_w-1:0]     r_data,    // Head word
    output logic                  r_ready    // Not empty
);

    // ======================================================================
    // Write pointer and full flag
    // ======================================================================

    logic [addr_w:0] w_bin;                 // Binary write pointer
    logic [addr_w:0] w_gray;                // Gray write pointer
    logic [addr_w:0] w_bin_next;
    logic [addr_w:0] w_gray_next;
    logic [addr_w:0] w_rgray_meta;          // First sync stage
    logic [addr_w:0] w_rgray;               // Read pointer in w_clk
    logic            w_full;

    // Caller guarantees w_ready, no second gating here
    assign w_bin_next  = w_trigger ? w_bin + 1'b1 : w_bin;
    assign w_gray_next = (w_bin_next >> 1) ^ w_bin_next;

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            w_bin        <= '0;
            w_gray       <= '0;
            w_rgray_meta <= '0;
            w_rgray      <= '0;
            w_full       <= 1'b0;
        end else begin
            w_bin        <= w_bin_next;
            w_gray       <= w_gray_next;
            w_rgray_meta <= r_gray;         // Crossing from r_clk
            w_rgray      <= w_rgray_meta;
            // Full when the pointers differ only in the two top bits
            w_full       <= (w_gray_next ==
                             {~w_rgray[addr_w:addr_w-1], w_rgray[addr_w-2:0]});
        end
    end

    assign w_ready = ~w_full;               // 1 out of reset

    // ======================================================================
    // Read pointer and not-empty flag
    // ======================================================================

    logic [addr_w:0] r_bin;                 // Binary read pointer
    logic [addr_w:0] r_gray;                // Gray read pointer
    logic [addr_w:0] r_bin_next;
    logic [addr_w:0] r_gray_next;
    logic [addr_w:0] r_wgray_meta;          // First sync stage
    logic [addr_w:0] r_wgray;               // Write pointer in r_clk
    logic            r_not_empty;

    assign r_bin_next  = r_trigger ? r_bin + 1'b1 : r_bin;
    assign r_gray_next = (r_bin_next >> 1) ^ r_bin_next;

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            r_bin        <= '0;
            r_gray       <= '0;
            r_wgray_meta <= '0;
            r_wgray      <= '0;
            r_not_empty  <= 1'b0;
        end else begin
            r_bin        <= r_bin_next;
            r_gray       <= r_gray_next;
            r_wgray_meta <= w_gray;         // Crossing from w_clk
            r_wgray      <= r_wgray_meta;
            r_not_empty  <= (r_gray_next != r_wgray);
        end
    end

    assign r_ready = r_not_empty;

    // ======================================================================
    // Storage
    // ======================================================================

    // Read address runs one pop ahead
    // so the next head is in rdata right after the edge
    fifo_ram u_ram (
        .w_clk (w_clk),
        .we    (w_trigger),
        .waddr (w_bin[addr_w-1:0]),
        .wdata (w_data),
        .r_clk (r_clk),
        .raddr (r_bin_next[addr_w-1:0]),
        .rdata (r_data)
    );

endmodule

// ==== rtl/capture_front.sv ====
`timescale 1ns/1ns

// Write-domain sample admission
// Drops samples on a full FIFO and flags it
module capture_front import capture_pkg::*; (
    input  logic                  rst_,

    input  logic                  w_clk,
    input  logic                  smp_valid, // Sample strobe from the source
    input  logic [data_w-1:0]     smp_data,  // Sample value
    input  logic                  cap_en,    // Enable level from r_clk domain

    input  logic                  w_ready,   // FIFO has space
    output logic                  w_trigger, // Push into the FIFO
    output logic [data_w-1:0]     w_data,
    output logic                  ovf_w      // Sticky overflow, level
);

    // ======================================================================
    // Enable synchronizer
    // ======================================================================

    logic en_meta;
    logic en_sync;

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            en_meta <= 1'b0;
            en_sync <= 1'b0;
        end else begin
            en_meta <= cap_en;              // Crossing from r_clk
            en_sync <= en_meta;
        end
    end

    // ======================================================================
    // Admission and overflow
    // ======================================================================

    // Push only with space, full FIFO means drop
    assign w_trigger = smp_valid & en_sync & w_ready;
    assign w_data    = smp_data;            // Payload passes straight on

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            ovf_w <= 1'b0;
        end else if (!en_sync) begin
            ovf_w <= 1'b0;                  // Disable clears the flag
        end else if (smp_valid && !w_ready) begin
            ovf_w <= 1'b1;                  // Enabled sample was dropped
        end
    end

endmodule

// ==== rtl/capture_regs.sv ====
`timescale 1ns/1ns

// APB register block in the system domain
// Holds the enable bit and pop counter, pops the FIFO on data reads
module capture_regs import capture_pkg::*; (
    input  logic                  rst_,
    input  logic                  r_clk,

    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [paddr_w-1:0]    paddr,
    input  logic [data_w-1:0]     pwdata,
    output logic [data_w-1:0]     prdata,   // 0 outside read access

    // FIFO read side
    input  logic [data_w-1:0]     r_data,   // Head word
    input  logic                  r_ready,  // Data available
    output logic                  r_trigger, // Pop

    // Crossings to and from the write domain
    output logic                  cap_en,   // Capture enable level
    input  logic                  ovf_w     // Overflow level from w_clk
);

    // ======================================================================
    // Access decode
    // ======================================================================

    logic acc;                              // Access phase
    logic wr_acc;
    logic rd_acc;

    assign acc    = psel & penable;
    assign wr_acc = acc & pwrite;
    assign rd_acc = acc & ~pwrite;

    // Pop at the end of the access cycle, only with data present
    assign r_trigger = rd_acc & (paddr == reg_data) & r_ready;

    // ======================================================================
    // Control, counter and overflow sync
    // ======================================================================

    logic [data_w-1:0] pop_cnt;             // Words popped since reset
    logic              ovf_meta;
    logic              ovf_sync;            // Overflow in r_clk

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            cap_en <= 1'b0;
        end else if (wr_acc && paddr == reg_ctrl) begin
            cap_en <= pwdata[0];            // Only bit 0 is writable
        end
    end

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            pop_cnt <= '0;
        end else if (r_trigger) begin
            pop_cnt <= pop_cnt + 1'b1;      // Wraps at 16 bits
        end
    end

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            ovf_meta <= 1'b0;
            ovf_sync <= 1'b0;
        end else begin
            ovf_meta <= ovf_w;              // Crossing from w_clk
            ovf_sync <= ovf_meta;
        end
    end

    // ======================================================================
    // Read mux
    // ======================================================================

    always_comb begin
        prdata = '0;
        if (rd_acc) begin
            case (paddr)
                reg_ctrl:   prdata[0] = cap_en;
                reg_status: begin
                    prdata[0] = r_ready;
                    prdata[1] = ovf_sync;
                end
                reg_data:   prdata = r_ready ? r_data : '0; // Empty reads 0
                reg_count:  prdata = pop_cnt;
                default:    prdata = '0;
            endcase
        end
    end

endmodule

// ==== rtl/capture_bridge.sv ====
`timescale 1ns/1ns

// Sample capture bridge
// Source samples in w_clk, CPU access over APB in r_clk
module capture_bridge import capture_pkg::*; (
    // Write domain
    input  logic                  w_clk,
    input  logic                  smp_valid, // Sample strobe
    input  logic [data_w-1:0]     smp_data,

    // System domain
    input  logic                  r_clk,
    input  logic                  rst_,     // Async, active low

    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [paddr_w-1:0]    paddr,
    input  logic [data_w-1:0]     pwdata,
    output logic [data_w-1:0]     prdata
);

    // ======================================================================
    // Interconnect
    // ======================================================================

    logic              w_trigger;           // Front to FIFO push
    logic [data_w-1:0] w_data;
    logic              w_ready;             // FIFO not full
    logic              r_trigger;           // Regs to FIFO pop
    logic [data_w-1:0] r_data;              // Head word
    logic              r_ready;             // FIFO not empty
    logic              cap_en;              // r_clk level to front
    logic              ovf_w;               // w_clk level to regs

    capture_front u_front (
        .rst_      (rst_),
        .w_clk     (w_clk),
        .smp_valid (smp_valid),
        .smp_data  (smp_data),
        .cap_en    (cap_en),
        .w_ready   (w_ready),
        .w_trigger (w_trigger),
        .w_data    (w_data),
        .ovf_w     (ovf_w)
    );

    async_fifo u_fifo (
        .rst_      (rst_),
        .w_clk     (w_clk),
        .w_trigger (w_trigger),
        .w_data    (w_data),
        .w_ready   (w_ready),
        .r_clk     (r_clk),
        .r_trigger (r_trigger),
        .r_data    (r_data),
        .r_ready   (r_ready)
    );

    capture_regs u_regs (
        .rst_      (rst_),
        .r_clk     (r_clk),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .r_data    (r_data),
        .r_ready   (r_ready),
        .r_trigger (r_trigger),
        .cap_en    (cap_en),
        .ovf_w     (ovf_w)
    );

endmodule

// ==== tests/capture_bridge_asserts.sv ====
`timescale 1ns/1ns

// Handshake and reset rules on the FIFO boundary
// Bound into every async_fifo instance
module capture_bridge_asserts (
    input logic rst_,
    input logic w_clk,
    input logic w_trigger,
    input logic w_ready,
    input logic r_clk,
    input logic r_trigger,
    input logic r_ready
);

    // Push only while the FIFO has space
    push_needs_space: assert property (
        @(posedge w_clk) disable iff (!rst_) w_trigger |-> w_ready
    ) else $error("Push into a full FIFO");

    // Pop only while data is present
    pop_needs_data: assert property (
        @(posedge r_clk) disable iff (!rst_) r_trigger |-> r_ready
    ) else $error("Pop from an empty FIFO");

    // Nothing can be available right out of reset
    empty_after_reset: assert property (
        @(posedge r_clk) $rose(rst_) |-> !r_ready
    ) else $error("Data available right after reset release");

endmodule

bind async_fifo capture_bridge_asserts u_asserts (
    .rst_      (rst_),
    .w_clk     (w_clk),
    .w_trigger (w_trigger),
    .w_ready   (w_ready),
    .r_clk     (r_clk),
    .r_trigger (r_trigger),
    .r_ready   (r_ready)
);

// ==== tests/capture_bridge_tb.sv ====
`timescale 1ns/1ns

module capture_bridge_tb import capture_pkg::*; ();

    // ======================================================================
    // Clocks, timing budget and DUT
    // ======================================================================

    localparam int r_period   = 4;
    localparam int w_period   = 6;          // Source clock, unrelated to r_clk
    localparam int poll_limit = 20;         // Status reads before giving up
    localparam int apb_ns     = 4 * r_period; // One access incl. alignment
    localparam int push_ns    = 2 * w_period;
    localparam int n_apb      = 60 + 5 * poll_limit;
    localparam int n_push     = 40;
    localparam int watchdog_ns = n_apb * apb_ns + n_push * push_ns + 1000;

    logic              r_clk = 1'b0;
    logic              w_clk = 1'b0;
    logic              rst_;
    logic              smp_valid;
    logic [data_w-1:0] smp_data;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [paddr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;

    integer            seed = 32'hacfd;
    int                errors = 0;
    int                checks = 0;
    int                pops_exp = 0;     // Words the model says were popped
    logic [data_w-1:0] exp_q[$];            // Samples expected in order

    always #(r_period/2) r_clk = ~r_clk;
    always #(w_period/2) w_clk = ~w_clk;

    capture_bridge DUT (
        .w_clk     (w_clk),
        .smp_valid (smp_valid),
        .smp_data  (smp_data),
        .r_clk     (r_clk),
        .rst_      (rst_),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata)
    );

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [data_w-1:0] next_sample();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[data_w-1:0];
    endfunction

    task automatic check_equal(input string what, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error at %0t: %s read 0x%04h, expected 0x%04h",
                     $time, what, got, exp);
        end
    endtask

    task automatic apb_write(input logic [paddr_w-1:0] addr, input logic [data_w-1:0] data);
        @(posedge r_clk);
        #1;
        psel    = 1'b1;                     // Setup cycle
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge r_clk);
        #1;
        penable = 1'b1;                     // Access cycle
        @(posedge r_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [paddr_w-1:0] addr, output logic [data_w-1:0] data);
        @(posedge r_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge r_clk);
        #1;
        penable = 1'b1;
        #1 data = prdata;                   // Mid access cycle
        @(posedge r_clk);                   // Pop lands on this edge
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // One sample, valid for a single w_clk cycle
    task automatic push_sample(input logic [data_w-1:0] data);
        @(posedge w_clk);
        #1;
        smp_valid = 1'b1;
        smp_data  = data;
        @(posedge w_clk);
        #1;
        smp_valid = 1'b0;
    endtask

    task automatic wait_status(input logic [data_w-1:0] mask,
                               input logic [data_w-1:0] value, input string what);
        logic [data_w-1:0] st;
        int tries;
        tries = 0;
        apb_read(reg_status, st);
        while (((st & mask) != value) && tries < poll_limit) begin
            tries++;
            apb_read(reg_status, st);
        end
        checks++;
        assert ((st & mask) == value) else begin
            errors++;
            $display("Status poll gave up at %0t, %s never showed in reg_status",
                     $time, what);
        end
    endtask

    task automatic drain_expected(input string what);
        logic [data_w-1:0] rd;
        while (exp_q.size() > 0) begin
            apb_read(reg_data, rd);
            check_equal(what, rd, exp_q.pop_front());
            pops_exp++;
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic reset_values();
        logic [data_w-1:0] rd;
        apb_read(reg_ctrl, rd);
        check_equal("reg_ctrl after reset", rd, 16'h0000);
        apb_read(reg_status, rd);
        check_equal("reg_status after reset", rd, 16'h0000);
        apb_read(reg_count, rd);
        check_equal("reg_count after reset", rd, 16'h0000);
        apb_read(reg_data, rd);
        check_equal("reg_data after reset", rd, 16'h0000);
    endtask

    task automatic disabled_ignores();
        logic [data_w-1:0] rd;
        repeat (4) push_sample(next_sample());  // Capture still off
        for (int i = 0; i < 8; i++) begin
            apb_read(reg_status, rd);
            check_equal("reg_status while disabled", rd, 16'h0000);
        end
    endtask

    task automatic enabled_flow(input int n, input string what);
        logic [data_w-1:0] rd;
        logic [data_w-1:0] smp;
        apb_write(reg_ctrl, 16'h0001);
        apb_read(reg_ctrl, rd);
        check_equal("reg_ctrl enable", rd, 16'h0001);
        repeat (4) @(posedge w_clk);        // Enable crosses two w_clk flops
        for (int i = 0; i < n; i++) begin
            smp = next_sample();
            exp_q.push_back(smp);
            push_sample(smp);
        end
        wait_status(16'h0001, 16'h0001, "data available");
        drain_expected(what);
        apb_read(reg_count, rd);
        check_equal("reg_count after stream", rd, pops_exp[data_w-1:0]);
    endtask

    task automatic overflow_drop();
        logic [data_w-1:0] rd;
        logic [data_w-1:0] smp;
        for (int i = 0; i < depth + 4; i++) begin
            smp = next_sample();
            if (i < depth) begin
                exp_q.push_back(smp);       // Later ones meet a full FIFO
            end
            push_sample(smp);
        end
        wait_status(16'h0002, 16'h0002, "overflow");
        drain_expected("reg_data after overflow");
        apb_read(reg_status, rd);
        check_equal("reg_status after drain", rd, 16'h0002);
    endtask

    task automatic empty_read();
        logic [data_w-1:0] rd;
        apb_read(reg_data, rd);
        check_equal("reg_data while empty", rd, 16'h0000);
        apb_read(reg_count, rd);
        check_equal("reg_count after empty read", rd, pops_exp[data_w-1:0]);
    endtask

    task automatic disable_clears_overflow();
        logic [data_w-1:0] rd;
        apb_write(reg_ctrl, 16'h0000);
        wait_status(16'h0002, 16'h0000, "overflow clear");
        enabled_flow(3, "reg_data after re-enable");
        apb_read(reg_status, rd);
        check_equal("reg_status at end", rd, 16'h0000);
    endtask

    // ======================================================================
    // Sequence, handshake monitor and watchdog
    // ======================================================================

    // Mid-cycle sampling keeps the handshake check off the clock edge
    always @(negedge w_clk) begin
        if (rst_) begin
            assert (!(DUT.u_fifo.w_trigger && !DUT.u_fifo.w_ready)) else begin
                errors++;
                $display("Push was issued to a full FIFO at %0t", $time);
            end
        end
    end

    always @(negedge r_clk) begin
        if (rst_) begin
            assert (!(DUT.u_fifo.r_trigger && !DUT.u_fifo.r_ready)) else begin
                errors++;
                $display("Pop was issued to an empty FIFO at %0t", $time);
            end
        end
    end

    initial begin
        rst_      = 1'b0;
        smp_valid = 1'b0;
        smp_data  = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (2) @(posedge r_clk);
        #1 rst_ = 1'b1;

        reset_values();
        disabled_ignores();
        enabled_flow(10, "reg_data in stream");
        overflow_drop();
        empty_read();
        disable_clears_overflow();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== capture_bridge.f ====
rtl/capture_pkg.sv
rtl/fifo_ram.sv
rtl/async_fifo.sv
rtl/capture_front.sv
rtl/capture_regs.sv
rtl/capture_bridge.sv
tests/capture_bridge_asserts.sv
tests/capture_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the capture bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=capture_bridge_sim

verilator --binary --timing --assert -j 0 \
    --top-module capture_bridge_tb -f capture_bridge.f -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$SIM" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
